//--- verilog.f
+incdir+include
verilog/frame_tx_pkg.sv
verilog/frame_buffer.sv
verilog/crc32_byte.sv
verilog/tx_frame_ctrl.sv
verilog/symbol_serializer.sv
verilog/frame_tx_top.sv
testbench/frame_tx_chk.sv
testbench/frame_tx_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the frame transmitter testbench with Verilator and run it
verilator --binary --assert -Wno-fatal -f verilog.f --top-module frame_tx_tb \
  -o frame_tx_sim \
  && ./obj_dir/frame_tx_sim | tee /dev/stderr | grep "test passed" > /dev/null \
  && echo "simulation ok" \
  || { echo "simulation did not pass"; exit 1; }

//--- testbench/frame_tx_tb.sv
`timescale 1ns/1ps
`include "frame_tx_params.svh"

module frame_tx_tb;

  logic                clk;
  logic                reset;
  logic                buf_wr_en;
  frame_tx_pkg::len_t  buf_wr_addr;
  frame_tx_pkg::byte_t buf_wr_data;
  frame_tx_pkg::len_t  data_length;
  logic                tx_start;
  logic                tx_busy;
  logic                line_bit;
  logic                line_strobe;
  logic                line_ctrl;

  logic [31:0]         lfsr_state = 32'hef83;
  frame_tx_pkg::byte_t payload [0:`BUF_DEPTH-1];   // expected frame contents
  frame_tx_pkg::byte_t sym_q [$];                  // decoded line symbols
  logic                ctrl_q [$];
  frame_tx_pkg::byte_t shift_in;
  logic                sym_is_ctrl;
  int                  bit_pos = 0;
  int                  strobe_count = 0;
  int                  errors = 0;
  int                  tests_run = 0;
  int                  tests_bad = 0;

  frame_tx_top dut
  (
    .clk         (clk),
    .reset       (reset),
    .buf_wr_en   (buf_wr_en),
    .buf_wr_addr (buf_wr_addr),
    .buf_wr_data (buf_wr_data),
    .data_length (data_length),
    .tx_start    (tx_start),
    .tx_busy     (tx_busy),
    .line_bit    (line_bit),
    .line_strobe (line_strobe),
    .line_ctrl   (line_ctrl)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // taps 32 22 2 1
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
      v = {v[30:0], lfsr_bit()};
    return v;
  endfunction

  // bitwise crc-32 over payload[0..len-1], msb first
  function automatic frame_tx_pkg::crc_t ref_crc(input int len);
    frame_tx_pkg::crc_t r;
    logic fb;
    r = `CRC_INIT;
    for (int n = 0; n < len; n++)
    begin
      for (int b = 7; b >= 0; b--)
      begin
        fb = r[31] ^ payload[n][b];
        r = {r[30:0], 1'b0};
        if (fb)
          r = r ^ `CRC_POLY;
      end
    end
    return r ^ `CRC_XOROUT;
  endfunction

  // line decoder, lsb arrives first
  always @(posedge clk)
  begin
    if (reset)
      bit_pos = 0;
    else if (line_strobe)
    begin
      strobe_count++;
      if (bit_pos == 0)
        sym_is_ctrl = line_ctrl;
      else if (line_ctrl !== sym_is_ctrl)
        sym_is_ctrl = 1'bx;                   // ctrl flag not steady over the symbol
      shift_in = {line_bit, shift_in[7:1]};
      bit_pos++;
      if (bit_pos == 8)
      begin
        sym_q.push_back(shift_in);
        ctrl_q.push_back(sym_is_ctrl);
        bit_pos = 0;
      end
    end
  end

  task automatic check_byte(input string name, input frame_tx_pkg::byte_t exp,
                            input frame_tx_pkg::byte_t act);
    if (exp !== act)
    begin
      $display("ERROR %s: expected %02h actual %02h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_crc(input string name, input frame_tx_pkg::crc_t exp,
                           input frame_tx_pkg::crc_t act);
    if (exp !== act)
    begin
      $display("ERROR %s: expected crc %08h actual %08h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_len(input string name, input frame_tx_pkg::len_t exp,
                           input frame_tx_pkg::len_t act);
    if (exp !== act)
    begin
      $display("ERROR %s: expected count %0d actual %0d", name, exp, act);
      errors++;
    end
  endtask

  task automatic wait_busy(input string name, input logic level, input int limit);
    int n;
    n = 0;
    while (tx_busy !== level && n < limit)
    begin
      @(negedge clk);
      n++;
    end
    if (tx_busy !== level)
    begin
      $display("%s: tx_busy did not go %0b within %0d cycles", name, level, limit);
      errors++;
    end
  endtask

  task automatic wait_symbols(input string name, input int count, input int limit);
    int n;
    n = 0;
    while (sym_q.size() < count && n < limit)
    begin
      @(negedge clk);
      n++;
    end
    if (sym_q.size() < count)
    begin
      $display("%s: only %0d of %0d symbols arrived in time", name, sym_q.size(), count);
      errors++;
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  task automatic write_payload(input int len);
    for (int i = 0; i < len; i++)
    begin
      @(negedge clk);
      buf_wr_en   = 1'b1;
      buf_wr_addr = frame_tx_pkg::len_t'(i);
      buf_wr_data = payload[i];
    end
    @(negedge clk);
    buf_wr_en = 1'b0;
  endtask

  task automatic pulse_start();
    @(negedge clk);
    tx_start = 1'b1;
    @(negedge clk);
    tx_start = 1'b0;
  endtask

  // start delimiter, payload, crc msb first, end delimiter
  task automatic check_frame(input string name, input int len);
    frame_tx_pkg::crc_t got_crc;
    int data_syms;
    data_syms = 0;
    for (int i = 0; i < ctrl_q.size(); i++)
    begin
      if (ctrl_q[i] === 1'b0)
        data_syms++;
    end
    check_len(name, frame_tx_pkg::len_t'(len), frame_tx_pkg::len_t'(data_syms - 4));
    check_len(name, frame_tx_pkg::len_t'(len + 6), frame_tx_pkg::len_t'(sym_q.size()));
    if (sym_q.size() == len + 6)
    begin
      for (int i = 0; i < len + 6; i++)
      begin
        if (ctrl_q[i] !== (i == 0 || i == len + 5))
        begin
          $display("ERROR %s: symbol %0d ctrl flag expected %0b actual %0b", name, i,
                   (i == 0 || i == len + 5), ctrl_q[i]);
          errors++;
        end
      end
      check_byte(name, `SYM_START, sym_q[0]);
      for (int i = 0; i < len; i++)
        check_byte(name, payload[i], sym_q[i + 1]);
      got_crc = {sym_q[len + 1], sym_q[len + 2], sym_q[len + 3], sym_q[len + 4]};
      check_crc(name, ref_crc(len), got_crc);
      check_byte(name, `SYM_END, sym_q[len + 5]);
    end
  endtask

  task automatic run_frame(input string name, input int len);
    sym_q.delete();
    ctrl_q.delete();
    data_length = frame_tx_pkg::len_t'(len);
    pulse_start();
    wait_busy(name, 1'b1, 10);
    wait_busy(name, 1'b0, 5000);
    wait_symbols(name, len + 6, 100);
    idle_cycles(40);                          // line settles, catches stray symbols
    check_frame(name, len);
  endtask

  task automatic finish_test(input string name, input int err_before);
    tests_run++;
    if (errors != err_before)
    begin
      tests_bad++;
      $display("%s: %0d errors", name, errors - err_before);
    end
    else
      $display("%s: ok", name);
  endtask

  task automatic test_reset_idle();
    int e0;
    int s0;
    e0 = errors;
    s0 = strobe_count;
    if (tx_busy !== 1'b0)
    begin
      $display("ERROR reset_idle: tx_busy expected 0 actual %0b", tx_busy);
      errors++;
    end
    idle_cycles(50);
    if (strobe_count != s0)
    begin
      $display("reset_idle: line_strobe pulsed %0d times with no frame", strobe_count - s0);
      errors++;
    end
    finish_test("reset_idle", e0);
  endtask

  task automatic test_single_byte();
    int e0;
    e0 = errors;
    payload[0] = frame_tx_pkg::byte_t'(rand_bits(8));
    write_payload(1);
    run_frame("single_byte", 1);
    finish_test("single_byte", e0);
  endtask

  task automatic test_random_len();
    int e0;
    int len;
    e0 = errors;
    len = int'(rand_bits(6)) + 1;             // 1 to 64
    for (int i = 0; i < len; i++)
      payload[i] = frame_tx_pkg::byte_t'(rand_bits(8));
    write_payload(len);
    run_frame("random_len", len);
    finish_test("random_len", e0);
  endtask

  task automatic test_zero_len();
    int e0;
    e0 = errors;
    run_frame("zero_len", 0);
    if (sym_q.size() == 6)
      check_crc("zero_len", 32'h00000000, {sym_q[1], sym_q[2], sym_q[3], sym_q[4]});
    finish_test("zero_len", e0);
  endtask

  task automatic test_restart_ignored();
    int e0;
    e0 = errors;
    for (int i = 0; i < 8; i++)
      payload[i] = frame_tx_pkg::byte_t'(rand_bits(8));
    write_payload(8);
    sym_q.delete();
    ctrl_q.delete();
    data_length = frame_tx_pkg::len_t'(8);
    pulse_start();
    wait_busy("restart_ignored", 1'b1, 10);
    idle_cycles(30);
    pulse_start();                            // mid-frame, must be dropped
    wait_busy("restart_ignored", 1'b0, 5000);
    wait_symbols("restart_ignored", 14, 100);
    idle_cycles(200);
    check_frame("restart_ignored", 8);
    for (int i = 0; i < 5; i++)
      payload[i] = frame_tx_pkg::byte_t'(rand_bits(8));
    write_payload(5);
    run_frame("restart_ignored", 5);          // fresh crc from init
    finish_test("restart_ignored", e0);
  endtask

  initial
  begin
    reset       = 1'b1;
    buf_wr_en   = 1'b0;
    buf_wr_addr = '0;
    buf_wr_data = '0;
    data_length = '0;
    tx_start    = 1'b0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    test_reset_idle();
    test_single_byte();
    test_random_len();
    test_zero_len();
    test_restart_ignored();
    $display("summary: %0d tests run, %0d with errors, %0d errors", tests_run, tests_bad,
             errors);
    if (errors == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

endmodule

//--- testbench/frame_tx_chk.sv
`timescale 1ns/1ps

module frame_tx_chk
(
  input logic               clk,
  input logic               reset,
  input logic               wr_en,
  input logic               ctrl_en,
  input logic               tx_rdy,
  input logic               tx_busy,
  input frame_tx_pkg::len_t rd_addr,
  input frame_tx_pkg::len_t frame_len
);

  issue_exclusive: assert property (@(posedge clk) disable iff (reset) !(wr_en && ctrl_en))
    else $error("wr_en and ctrl_en high in the same cycle");

  // an issue pulse only while the serializer is idle
  issue_when_ready: assert property (@(posedge clk) disable iff (reset)
    (wr_en || ctrl_en) |-> tx_rdy)
    else $error("symbol issued while tx_rdy low");

  idle_after_reset: assert property (@(posedge clk) $fell(reset) |-> !tx_busy)
    else $error("tx_busy high right after reset");

  addr_in_range: assert property (@(posedge clk) disable iff (reset) rd_addr <= frame_len)
    else $error("rd_addr %0d beyond frame length %0d", rd_addr, frame_len);

endmodule

bind tx_frame_ctrl frame_tx_chk chk
(
  .clk       (clk),
  .reset     (reset),
  .wr_en     (wr_en),
  .ctrl_en   (ctrl_en),
  .tx_rdy    (tx_rdy),
  .tx_busy   (tx_busy),
  .rd_addr   (rd_addr),
  .frame_len (frame_len)
);

//--- verilog/frame_tx_top.sv
`timescale 1ns/1ps

module frame_tx_top
(
  input  logic                clk,
  input  logic                reset,
  input  logic                buf_wr_en,
  input  frame_tx_pkg::len_t  buf_wr_addr,
  input  frame_tx_pkg::byte_t buf_wr_data,
  input  frame_tx_pkg::len_t  data_length,
  input  logic                tx_start,
  output logic                tx_busy,
  output logic                line_bit,
  output logic                line_strobe,
  output logic                line_ctrl
);

  logic                     rd_en;
  frame_tx_pkg::len_t       rd_addr;
  frame_tx_pkg::byte_t      rd_data;
  logic                     crc_init;
  logic                     crc_en;
  frame_tx_pkg::byte_t      crc_data;
  frame_tx_pkg::crc_t       crc_out;
  logic                     wr_en;
  logic                     ctrl_en;
  frame_tx_pkg::ctrl_code_t ctrl_code;
  frame_tx_pkg::byte_t      data_out;
  logic                     tx_rdy;

  frame_buffer u_buffer
  (
    .clk     (clk),
    .wr_en   (buf_wr_en),
    .wr_addr (buf_wr_addr),
    .wr_data (buf_wr_data),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  crc32_byte u_crc
  (
    .clk      (clk),
    .reset    (reset),
    .crc_init (crc_init),
    .crc_en   (crc_en),
    .crc_data (crc_data),
    .crc_out  (crc_out)
  );

  tx_frame_ctrl u_ctrl
  (
    .clk         (clk),
    .reset       (reset),
    .tx_start    (tx_start),
    .data_length (data_length),
    .tx_rdy      (tx_rdy),
    .rd_data     (rd_data),
    .crc_in      (crc_out),
    .rd_en       (rd_en),
    .rd_addr     (rd_addr),
    .crc_init    (crc_init),
    .crc_en      (crc_en),
    .crc_data    (crc_data),
    .wr_en       (wr_en),
    .ctrl_en     (ctrl_en),
    .ctrl_code   (ctrl_code),
    .data_out    (data_out),
    .tx_busy     (tx_busy)
  );

  symbol_serializer u_ser
  (
    .clk         (clk),
    .reset       (reset),
    .wr_en       (wr_en),
    .ctrl_en     (ctrl_en),
    .ctrl_code   (ctrl_code),
    .data_in     (data_out),
    .tx_rdy      (tx_rdy),
    .line_bit    (line_bit),
    .line_strobe (line_strobe),
    .line_ctrl   (line_ctrl)
  );

endmodule

//--- verilog/symbol_serializer.sv
`timescale 1ns/1ps
`include "frame_tx_params.svh"

module symbol_serializer
(
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     wr_en,
  input  logic                     ctrl_en,
  input  frame_tx_pkg::ctrl_code_t ctrl_code,
  input  frame_tx_pkg::byte_t      data_in,
  output logic                     tx_rdy,
  output logic                     line_bit,
  output logic                     line_strobe,
  output logic                     line_ctrl
);

  localparam int PW = $clog2(`BIT_CYCLES + 1);
  localparam logic [PW-1:0] PERIOD_LAST = PW'(`BIT_CYCLES - 1);

  logic                busy;
  logic                sym_ctrl;          // current symbol is a delimiter
  logic [PW-1:0]       period_cnt;
  logic [2:0]          bit_cnt;
  logic                issue;
  logic                bit_end;
  frame_tx_pkg::byte_t load_value;
  frame_tx_pkg::byte_t shift_reg;

  assign issue   = ~busy & (wr_en | ctrl_en);
  assign bit_end = busy & (period_cnt == PERIOD_LAST);

  always_comb
  begin
    if (!ctrl_en)
      load_value = data_in;
    else if (ctrl_code == frame_tx_pkg::CTRL_END)
      load_value = `SYM_END;
    else
      load_value = `SYM_START;
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      busy       <= 1'b0;
      sym_ctrl   <= 1'b0;
      period_cnt <= '0;
      bit_cnt    <= '0;
    end
    else if (issue)
    begin
      busy       <= 1'b1;
      sym_ctrl   <= ctrl_en;
      period_cnt <= '0;
      bit_cnt    <= '0;
    end
    else if (bit_end)
    begin
      period_cnt <= '0;
      bit_cnt    <= bit_cnt + 3'd1;
      if (bit_cnt == 3'd7)
        busy <= 1'b0;                     // last bit period over
    end
    else if (busy)
      period_cnt <= period_cnt + 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (issue)
      shift_reg <= load_value;
    else if (bit_end)
      shift_reg <= shift_reg >> 1;        // lsb first
  end

  assign tx_rdy      = ~busy;
  assign line_bit    = shift_reg[0];
  assign line_strobe = busy & (period_cnt == '0);
  assign line_ctrl   = busy & sym_ctrl;

endmodule

//--- verilog/tx_frame_ctrl.sv
`timescale 1ns/1ps

module tx_frame_ctrl
(
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     tx_start,
  input  frame_tx_pkg::len_t       data_length,
  input  logic                     tx_rdy,
  input  frame_tx_pkg::byte_t      rd_data,
  input  frame_tx_pkg::crc_t       crc_in,
  output logic                     rd_en,
  output frame_tx_pkg::len_t       rd_addr,
  output logic                     crc_init,
  output logic                     crc_en,
  output frame_tx_pkg::byte_t      crc_data,
  output logic                     wr_en,
  output logic                     ctrl_en,
  output frame_tx_pkg::ctrl_code_t ctrl_code,
  output frame_tx_pkg::byte_t      data_out,
  output logic                     tx_busy
);

  frame_tx_pkg::tx_state_t state;

  logic               tx_start_d;
  logic               tx_rdy_d;
  logic               start_edge;
  logic               rdy_edge;
  frame_tx_pkg::len_t frame_len;           // latched at acceptance
  frame_tx_pkg::len_t byte_cnt;            // payload bytes issued
  frame_tx_pkg::crc_t crc_buf;
  logic [2:0]         crc_cnt;             // crc bytes issued

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      tx_start_d <= 1'b0;
      tx_rdy_d   <= 1'b1;                  // serializer is ready out of reset
    end
    else
    begin
      tx_start_d <= tx_start;
      tx_rdy_d   <= tx_rdy;
    end
  end

  assign start_edge = tx_start & ~tx_start_d;
  assign rdy_edge   = tx_rdy & ~tx_rdy_d;

  assign tx_busy = (state != frame_tx_pkg::IDLE);

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      state     <= frame_tx_pkg::IDLE;
      rd_en     <= 1'b0;
      rd_addr   <= '0;
      crc_init  <= 1'b0;
      crc_en    <= 1'b0;
      crc_data  <= '0;
      wr_en     <= 1'b0;
      ctrl_en   <= 1'b0;
      ctrl_code <= frame_tx_pkg::CTRL_START;
      data_out  <= '0;
      frame_len <= '0;
      byte_cnt  <= '0;
      crc_buf   <= '0;
      crc_cnt   <= '0;
    end
    else
    begin
      // strobes last one cycle
      rd_en    <= 1'b0;
      crc_init <= 1'b0;
      crc_en   <= 1'b0;
      wr_en    <= 1'b0;
      ctrl_en  <= 1'b0;
      case (state)
        frame_tx_pkg::IDLE:
        begin
          if (start_edge && tx_rdy)
          begin
            frame_len <= data_length;
            byte_cnt  <= '0;
            crc_cnt   <= '0;
            rd_addr   <= '0;
            rd_en     <= 1'b1;             // prefetch first byte
            crc_init  <= 1'b1;
            state     <= frame_tx_pkg::LOAD;
          end
        end
        frame_tx_pkg::LOAD:
        begin
          ctrl_en   <= 1'b1;               // start delimiter
          ctrl_code <= frame_tx_pkg::CTRL_START;
          state     <= frame_tx_pkg::SEND_START;
        end
        frame_tx_pkg::SEND_START:
          state <= frame_tx_pkg::WAIT_DATA;
        frame_tx_pkg::WAIT_DATA:
        begin
          if (rdy_edge)
          begin
            if (byte_cnt < frame_len)
            begin
              data_out <= rd_data;
              crc_data <= rd_data;
              wr_en    <= 1'b1;
              crc_en   <= 1'b1;
              byte_cnt <= byte_cnt + 1'b1;
              rd_addr  <= rd_addr + 1'b1;
              rd_en    <= 1'b1;            // next byte ready long before next edge
              state    <= frame_tx_pkg::SEND_DATA;
            end
            else
            begin
              // payload done, crc has settled by now
              data_out <= crc_in[31:24];
              crc_buf  <= {crc_in[23:0], 8'h00};
              wr_en    <= 1'b1;
              crc_cnt  <= 3'd1;
              state    <= frame_tx_pkg::SEND_CRC;
            end
          end
        end
        frame_tx_pkg::SEND_DATA:
          state <= frame_tx_pkg::WAIT_DATA;
        frame_tx_pkg::SEND_CRC:
        begin
          if (rdy_edge)
          begin
            if (crc_cnt == 3'd4)
            begin
              ctrl_en   <= 1'b1;           // end delimiter
              ctrl_code <= frame_tx_pkg::CTRL_END;
              state     <= frame_tx_pkg::SEND_END;
            end
            else
            begin
              data_out <= crc_buf[31:24];
              crc_buf  <= {crc_buf[23:0], 8'h00};
              wr_en    <= 1'b1;
              crc_cnt  <= crc_cnt + 3'd1;
            end
          end
        end
        frame_tx_pkg::SEND_END:
          state <= frame_tx_pkg::DONE;
        frame_tx_pkg::DONE:
          state <= frame_tx_pkg::IDLE;     // busy drops next cycle
        default:
          state <= frame_tx_pkg::IDLE;
      endcase
    end
  end

endmodule

//--- verilog/crc32_byte.sv
`timescale 1ns/1ps
`include "frame_tx_params.svh"

module crc32_byte
(
  input  logic                clk,
  input  logic                reset,
  input  logic                crc_init,
  input  logic                crc_en,
  input  frame_tx_pkg::byte_t crc_data,
  output frame_tx_pkg::crc_t  crc_out
);

  frame_tx_pkg::crc_t crc_reg;

  // eight polynomial steps, data msb first
  function automatic frame_tx_pkg::crc_t crc_step(input frame_tx_pkg::crc_t crc,
                                                  input frame_tx_pkg::byte_t data);
    frame_tx_pkg::crc_t c;
    c = crc;
    for (int i = 7; i >= 0; i--)
    begin
      if (c[31] ^ data[i])
        c = (c << 1) ^ `CRC_POLY;
      else
        c = c << 1;
    end
    return c;
  endfunction

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      crc_reg <= `CRC_INIT;
    else if (crc_init)                     // init wins over a byte
      crc_reg <= `CRC_INIT;
    else if (crc_en)
      crc_reg <= crc_step(crc_reg, crc_data);
  end

  // empty payload gives zero
  assign crc_out = crc_reg ^ `CRC_XOROUT;

endmodule

//--- verilog/frame_buffer.sv
`timescale 1ns/1ps
`include "frame_tx_params.svh"

module frame_buffer
(
  input  logic                clk,
  input  logic                wr_en,
  input  frame_tx_pkg::len_t  wr_addr,
  input  frame_tx_pkg::byte_t wr_data,
  input  logic                rd_en,
  input  frame_tx_pkg::len_t  rd_addr,
  output frame_tx_pkg::byte_t rd_data
);

  localparam int ADDR_W = $clog2(`BUF_DEPTH);

  frame_tx_pkg::byte_t mem [0:`BUF_DEPTH-1];

  // host port, written between frames
  always_ff @(posedge clk)
  begin
    if (wr_en)
      mem[wr_addr[ADDR_W-1:0]] <= wr_data;
  end

  // controller port, one cycle read latency
  always_ff @(posedge clk)
  begin
    if (rd_en)
      rd_data <= mem[rd_addr[ADDR_W-1:0]];
  end

endmodule

//--- verilog/frame_tx_pkg.sv
`include "frame_tx_params.svh"

package frame_tx_pkg;

  typedef logic [7:0] byte_t;          // payload or line byte
  typedef logic [`LEN_W-1:0] len_t;    // length or buffer address
  typedef logic [31:0] crc_t;
  typedef logic [0:0] ctrl_code_t;     // delimiter selector

  localparam ctrl_code_t CTRL_START = 1'b0;
  localparam ctrl_code_t CTRL_END = 1'b1;

  typedef enum logic [2:0]
  {
    IDLE,
    LOAD,
    SEND_START,
    WAIT_DATA,
    SEND_DATA,
    SEND_CRC,
    SEND_END,
    DONE
  } tx_state_t;

endpackage

//--- include/frame_tx_params.svh
`ifndef FRAME_TX_PARAMS_SVH
`define FRAME_TX_PARAMS_SVH

// payload buffer
`define BUF_DEPTH 1024
`define LEN_W 11

// line timing, clocks per bit
`define BIT_CYCLES 2

// delimiter patterns
`define SYM_START 8'hC5
`define SYM_END 8'hFD

// crc-32, non-reflected, msb first
`define CRC_POLY 32'h04C11DB7
`define CRC_INIT 32'hFFFFFFFF
`define CRC_XOROUT 32'hFFFFFFFF

`endif
